/* rtl/wb_bus_ctrl.sv */
// Bus control with request masking, bus hold, grant gating and grant registers

`timescale 1ns/1ps

module wb_bus_ctrl (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  wb_bus_pkg::mst_vec_t cyc_i,
   input  logic                 bus_hold_i,
   output logic                 bus_hold_ack_o,
   output wb_bus_pkg::mst_vec_t grant_o
);

   import wb_cfg_pkg::*;
   import wb_bus_pkg::*;

   // Requests seen by the arbiter after masking
   mst_vec_t arb_req;
   // Raw arbiter result, before hold gating
   mst_vec_t nxt_gnt;
   // Arbiter result from last cycle, drives the round-robin pointer
   mst_vec_t prev_arb_gnt;
   // Gated grant from last cycle, kept only if that master had cyc up
   // Tells who owns the bus
   mst_vec_t prev_gnt;

   // Ownership check
   // The owner keeps the bus as long as its cyc stays high
   always_comb begin
      if (|(cyc_i & prev_gnt)) begin
         // Bus not released, only the owner may win
         arb_req        = prev_gnt;
         // A hold waits for the owner to finish
         bus_hold_ack_o = 1'b0;
      end else begin
         // Bus free, open arbitration to every cyc
         arb_req        = cyc_i;
         bus_hold_ack_o = bus_hold_i;
      end
   end

   wb_rr_arbiter i_wb_rr_arbiter (
      .req_i     (arb_req),
      .gnt_i     (prev_arb_gnt),
      .nxt_gnt_o (nxt_gnt)
   );

   // No master gets the bus while the hold is acknowledged
   assign grant_o = nxt_gnt & {N_MASTERS{~bus_hold_ack_o}};

   // Both grants are sampled every cycle
   // Reset points both at master 0
   // An idle grant does not make its master the owner
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         prev_arb_gnt <= mst_vec_t'(1);
         prev_gnt     <= mst_vec_t'(1);
      end else begin
         prev_arb_gnt <= nxt_gnt;
         prev_gnt     <= grant_o & cyc_i;
      end
   end

endmodule : wb_bus_ctrl

/* rtl/wb_bus_pkg.sv */
// Wishbone vector typedefs and request/response structs for the shared bus

package wb_bus_pkg;

   import wb_cfg_pkg::*;

   // Byte address on the bus
   typedef logic [ADDR_W-1:0] wb_adr_t;

   // One data word
   typedef logic [DATA_W-1:0] wb_dat_t;

   // Byte-lane selects
   typedef logic [SEL_W-1:0] wb_sel_t;

   // One bit per master
   // Used for the cyc vector and all grant vectors
   typedef logic [N_MASTERS-1:0] mst_vec_t;

   // Request from one master, classic cycles only
   typedef struct packed {
      logic    cyc;
      logic    stb;
      logic    we;
      wb_adr_t adr;
      wb_sel_t sel;
      wb_dat_t dat;
   } wb_req_t;

   // Response to one master
   // No retry, the slave never raises it
   typedef struct packed {
      logic    ack;
      logic    err;
      wb_dat_t dat;
   } wb_rsp_t;

   // All master requests, index is the master number
   typedef wb_req_t [N_MASTERS-1:0] wb_req_arr_t;

   // All master responses, index is the master number
   typedef wb_rsp_t [N_MASTERS-1:0] wb_rsp_arr_t;

endpackage : wb_bus_pkg

/* rtl/wb_cfg_pkg.sv */
// Bus geometry and RAM size constants for the shared Wishbone bus

package wb_cfg_pkg;

   // Number of masters sharing the bus
   localparam int N_MASTERS = 4;

   // Address width in bits, byte addressed
   localparam int ADDR_W = 32;

   // Data width in bits
   // Must stay a multiple of 8 so byte lanes line up
   localparam int DATA_W = 32;

   // One select bit per byte lane
   localparam int SEL_W = DATA_W / 8;

   // RAM depth in words
   localparam int RAM_WORDS = 256;

   // Word index width, log2 of RAM_WORDS
   // Word index sits at adr[RAM_AW+1:2]
   localparam int RAM_AW = 8;

endpackage : wb_cfg_pkg

/* rtl/wb_master_mux.sv */
// Request mux from the granted master to the slave and response routing back to masters

`timescale 1ns/1ps

module wb_master_mux (
   input  wb_bus_pkg::mst_vec_t    grant_i,
   input  wb_bus_pkg::wb_req_arr_t m_req_i,
   output wb_bus_pkg::wb_rsp_arr_t m_rsp_o,
   output wb_bus_pkg::wb_req_t     s_req_o,
   input  wb_bus_pkg::wb_rsp_t     s_rsp_i
);

   import wb_cfg_pkg::*;

   // Request path
   // Grant is one-hot or zero, so at most one master is copied
   always_comb begin
      // Idle bus drives zeros, cyc and stb included
      s_req_o = '0;
      for (int i = 0; i < N_MASTERS; i++) begin
         if (grant_i[i]) begin
            s_req_o = m_req_i[i];
         end
      end
   end

   // Response path
   always_comb begin
      for (int i = 0; i < N_MASTERS; i++) begin
         // Read data is broadcast, harmless without an ack
         m_rsp_o[i].dat = s_rsp_i.dat;
         // Handshake only reaches the owner
         m_rsp_o[i].ack = grant_i[i] & s_rsp_i.ack;
         m_rsp_o[i].err = grant_i[i] & s_rsp_i.err;
      end
   end

endmodule : wb_master_mux

/* rtl/wb_ram_slave.sv */
// Wishbone RAM slave with byte selects, registered ack and out-of-range err

`timescale 1ns/1ps

module wb_ram_slave (
   input  logic                clk_i,
   input  logic                rst_i,
   input  wb_bus_pkg::wb_req_t req_i,
   output wb_bus_pkg::wb_rsp_t rsp_o
);

   import wb_cfg_pkg::*;
   import wb_bus_pkg::*;

   // Storage, no reset
   wb_dat_t mem [RAM_WORDS];

   // Decoded word index
   logic [RAM_AW-1:0] word_idx;
   // Any address bit above the RAM range set
   logic              out_of_range;
   // Valid strobe with no response going out this cycle
   logic              access;

   // Response registers
   logic              ack_q;
   logic              err_q;
   wb_dat_t           rd_dat_q;

   assign word_idx     = req_i.adr[RAM_AW+1:2];
   assign out_of_range = |req_i.adr[ADDR_W-1:RAM_AW+2];

   // Master keeps stb up during the ack cycle
   // so a pending response blocks a second access
   assign access = req_i.cyc & req_i.stb & ~(ack_q | err_q);

   // Handshake, one cycle after the strobe, one cycle long
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= access & ~out_of_range;
         err_q <= access & out_of_range;
      end
   end

   // Memory and read data
   // Out-of-range accesses leave both untouched
   always_ff @(posedge clk_i) begin
      if (access && !out_of_range) begin
         if (req_i.we) begin
            // Only the selected byte lanes are written
            for (int b = 0; b < SEL_W; b++) begin
               if (req_i.sel[b]) begin
                  mem[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
               end
            end
         end else begin
            rd_dat_q <= mem[word_idx];
         end
      end
   end

   assign rsp_o.ack = ack_q;
   assign rsp_o.err = err_q;
   assign rsp_o.dat = rd_dat_q;

endmodule : wb_ram_slave

/* rtl/wb_rr_arbiter.sv */
// Round-robin arbiter computing the next one-hot grant from requests and the last grant

`timescale 1ns/1ps

module wb_rr_arbiter (
   input  wb_bus_pkg::mst_vec_t req_i,
   input  wb_bus_pkg::mst_vec_t gnt_i,
   output wb_bus_pkg::mst_vec_t nxt_gnt_o
);

   import wb_cfg_pkg::*;
   import wb_bus_pkg::*;

   // Next grant built by the search below
   mst_vec_t nxt_gnt;

   always_comb begin : rr_search
      int   prev_idx;
      int   idx;
      logic found;

      // Locate the previous grant
      // gnt_i is one-hot, the last set bit wins if it ever is not
      prev_idx = 0;
      for (int i = 0; i < N_MASTERS; i++) begin
         if (gnt_i[i]) begin
            prev_idx = i;
         end
      end

      // No requests keeps the previous grant
      // so the grant vector never goes empty
      nxt_gnt = gnt_i;
      found   = 1'b0;

      // Start one past the previous winner and wrap around
      // The previous winner itself is checked last
      for (int k = 1; k <= N_MASTERS; k++) begin
         idx = prev_idx + k;
         if (idx >= N_MASTERS) begin
            idx = idx - N_MASTERS;
         end
         if (!found && req_i[idx]) begin
            nxt_gnt      = '0;
            nxt_gnt[idx] = 1'b1;
            found        = 1'b1;
         end
      end
   end

   assign nxt_gnt_o = nxt_gnt;

endmodule : wb_rr_arbiter

/* rtl/wb_shared_bus.sv */
// Shared Wishbone bus top with bus control, master mux and RAM slave

`timescale 1ns/1ps

module wb_shared_bus (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  wb_bus_pkg::wb_req_arr_t m_req_i,
   output wb_bus_pkg::wb_rsp_arr_t m_rsp_o,
   input  logic                    bus_hold_i,
   output logic                    bus_hold_ack_o
);

   import wb_cfg_pkg::*;
   import wb_bus_pkg::*;

   // cyc bits pulled out of the request structs
   mst_vec_t cyc;
   // One-hot or zero grant from the control block
   mst_vec_t grant;
   // Slave side of the mux
   wb_req_t  s_req;
   wb_rsp_t  s_rsp;

   // Gather cyc per master for arbitration
   for (genvar i = 0; i < N_MASTERS; i++) begin : g_cyc
      assign cyc[i] = m_req_i[i].cyc;
   end

   // Grant state, masking and hold
   wb_bus_ctrl i_wb_bus_ctrl (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .cyc_i          (cyc),
      .bus_hold_i     (bus_hold_i),
      .bus_hold_ack_o (bus_hold_ack_o),
      .grant_o        (grant)
   );

   // Request and response steering
   wb_master_mux i_wb_master_mux (
      .grant_i (grant),
      .m_req_i (m_req_i),
      .m_rsp_o (m_rsp_o),
      .s_req_o (s_req),
      .s_rsp_i (s_rsp)
   );

   // The only slave on the bus
   wb_ram_slave i_wb_ram_slave (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .req_i (s_req),
      .rsp_o (s_rsp)
   );

endmodule : wb_shared_bus

/* verif/tb_wb_shared_bus.sv */
// Testbench for the shared Wishbone bus with LFSR stimulus, master drivers, reference model and checks

`timescale 1ns/1ps

module tb_wb_shared_bus;

   import wb_cfg_pkg::*;
   import wb_bus_pkg::*;

   // Cycles a master waits for ack or err
   localparam int RESP_TIMEOUT = 400;
   // Random transfers per master
   localparam int RND_LEN = 12;

   logic        clk_i;
   logic        rst_i;
   wb_req_arr_t m_req;
   wb_rsp_arr_t m_rsp;
   logic        bus_hold_i;
   logic        bus_hold_ack_o;

   logic [31:0] lfsr = 32'ha6e93795;
   // RAM shadow, unwritten bytes stay X as in the RAM
   wb_dat_t     shadow [RAM_WORDS];
   // Master index per completed transfer
   int          done_order [$];
   wb_req_t     rnd_req [N_MASTERS][RND_LEN];
   int          sva_fails;

   assign sva_fails = i_wb_shared_bus.i_wb_bus_ctrl.i_wb_shared_bus_sva.fail_cnt;

   wb_shared_bus i_wb_shared_bus (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .m_req_i        (m_req),
      .m_rsp_o        (m_rsp),
      .bus_hold_i     (bus_hold_i),
      .bus_hold_ack_o (bus_hold_ack_o)
   );

   initial begin : clock_gen
      clk_i = 1'b0;
      forever begin
         #50 clk_i = ~clk_i;
      end
   end

   // Galois LFSR, taps x^32+x^31+x^29+x+1
   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'hd000_0001;
      end
      return s >> 1;
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic wb_adr_t word_adr(logic [RAM_AW-1:0] idx);
      return wb_adr_t'({idx, 2'b00});
   endfunction

   function automatic wb_req_t make_req(logic we, wb_adr_t adr, wb_sel_t sel, wb_dat_t dat);
      return '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
   endfunction

   // Random transfer in a 16-word window
   // About one in eight goes out of range
   function automatic wb_req_t rand_req();
      wb_adr_t adr;
      logic    we;
      wb_sel_t sel;
      wb_dat_t dat;
      adr = word_adr(8'h40 + 8'(rand_bits(4)));
      if (rand_bits(3) == 32'd0) begin
         adr[20] = 1'b1;
      end
      we  = (rand_bits(1) == 32'd1);
      sel = wb_sel_t'(rand_bits(SEL_W));
      dat = rand_bits(DATA_W);
      return make_req(we, adr, sel, dat);
   endfunction

   // Expected response, applies writes to the shadow
   function automatic wb_rsp_t ref_access(wb_req_t req);
      wb_rsp_t           rsp;
      logic [RAM_AW-1:0] idx;
      rsp = '0;
      idx = req.adr[RAM_AW+1:2];
      if (req.adr[ADDR_W-1:RAM_AW+2] != '0) begin
         // Outside the RAM, memory untouched
         rsp.err = 1'b1;
      end else begin
         rsp.ack = 1'b1;
         if (req.we) begin
            for (int b = 0; b < SEL_W; b++) begin
               if (req.sel[b]) begin
                  shadow[idx][8*b +: 8] = req.dat[8*b +: 8];
               end
            end
         end else begin
            rsp.dat = shadow[idx];
         end
      end
      return rsp;
   endfunction

   task automatic stop_run();
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic check_equal(string what, logic [63:0] got, logic [63:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %0h, expected %0h", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic start_req(int m, wb_req_t req);
      @(posedge clk_i);
      m_req[m] <= req;
   endtask

   // Sampled mid-cycle, away from the driving edge
   task automatic wait_resp(int m);
      int cnt;
      cnt = 0;
      @(negedge clk_i);
      while (!(m_rsp[m].ack || m_rsp[m].err)) begin
         if (cnt >= RESP_TIMEOUT) begin
            $display("Timeout: master %0d got no ack or err in %0d cycles", m, RESP_TIMEOUT);
            stop_run();
         end else begin
            cnt++;
            @(negedge clk_i);
         end
      end
   endtask

   // keep_cyc drops only stb so the master keeps the bus
   task automatic end_req(int m, logic keep_cyc);
      @(posedge clk_i);
      if (keep_cyc) begin
         m_req[m].stb <= 1'b0;
      end else begin
         m_req[m] <= '0;
      end
   endtask

   task automatic transfer(int m, wb_req_t req);
      start_req(m, req);
      wait_resp(m);
      end_req(m, 1'b0);
   endtask

   task automatic run_list(int m);
      for (int k = 0; k < RND_LEN; k++) begin
         transfer(m, rnd_req[m][k]);
      end
   endtask

   // Every response is checked against the shadow model
   always @(negedge clk_i) begin : compare_responses
      wb_rsp_t exp_rsp;
      if (rst_i === 1'b0) begin
         check_equal("bound assertion failures", sva_fails, 0);
         for (int m = 0; m < N_MASTERS; m++) begin
            if (m_rsp[m].ack || m_rsp[m].err) begin
               check_equal("response while hold acknowledged", bus_hold_ack_o, 1'b0);
               check_equal($sformatf("master %0d cyc and stb at response", m),
                           {m_req[m].cyc, m_req[m].stb}, 2'b11);
               exp_rsp = ref_access(m_req[m]);
               check_equal($sformatf("master %0d ack", m), m_rsp[m].ack, exp_rsp.ack);
               check_equal($sformatf("master %0d err", m), m_rsp[m].err, exp_rsp.err);
               if (exp_rsp.ack && !m_req[m].we) begin
                  check_equal($sformatf("master %0d read data", m), m_rsp[m].dat, exp_rsp.dat);
               end
               done_order.push_back(m);
            end
         end
      end
   end

   initial begin : main_sequence
      logic [RAM_AW-1:0] idx;
      wb_adr_t           adr;
      wb_sel_t           sel;
      wb_dat_t           dat;
      int                bit_pos;
      rst_i      = 1'b1;
      bus_hold_i = 1'b0;
      m_req      = '0;
      repeat (10) @(posedge clk_i);
      rst_i <= 1'b0;

      // Reset leaves the round-robin pointer on master 0
      // so master 1 wins first and master 0 comes last
      fork
         transfer(0, make_req(1'b1, word_adr(8'h10), 4'hf, 32'h0000_1000));
         transfer(1, make_req(1'b1, word_adr(8'h11), 4'hf, 32'h0000_1001));
         transfer(2, make_req(1'b1, word_adr(8'h12), 4'hf, 32'h0000_1002));
         transfer(3, make_req(1'b1, word_adr(8'h13), 4'hf, 32'h0000_1003));
      join
      check_equal("completions after reset", done_order.size(), 4);
      for (int k = 0; k < 4; k++) begin
         check_equal($sformatf("completion %0d after reset", k), done_order[k],
                     (k + 1) % N_MASTERS);
      end

      // Full write, byte-selected write, read back
      for (int m = 0; m < N_MASTERS; m++) begin
         idx = 8'(rand_bits(RAM_AW));
         dat = rand_bits(DATA_W);
         transfer(m, make_req(1'b1, word_adr(idx), 4'hf, dat));
         sel = wb_sel_t'(rand_bits(SEL_W));
         dat = rand_bits(DATA_W);
         transfer(m, make_req(1'b1, word_adr(idx), sel, dat));
         transfer(m, make_req(1'b0, word_adr(idx), 4'h0, 32'h0));
      end

      // Out-of-range write aliases an in-range word index
      idx = 8'(rand_bits(RAM_AW));
      transfer(2, make_req(1'b1, word_adr(idx), 4'hf, 32'h1234_5678));
      bit_pos = RAM_AW + 2 + int'(rand_bits(5) % (ADDR_W - RAM_AW - 2));
      adr     = word_adr(idx) | (wb_adr_t'(1) << bit_pos);
      transfer(2, make_req(1'b1, adr, 4'hf, 32'hdead_beef));
      transfer(2, make_req(1'b0, word_adr(idx), 4'h0, 32'h0));

      // Master 1 keeps cyc across two transfers
      done_order.delete();
      idx = 8'(rand_bits(RAM_AW));
      fork
         begin
            start_req(1, make_req(1'b1, word_adr(idx), 4'hf, 32'ha5a5_0001));
            wait_resp(1);
            end_req(1, 1'b1);
            start_req(1, make_req(1'b0, word_adr(idx), 4'h0, 32'h0));
            wait_resp(1);
            end_req(1, 1'b0);
         end
         begin
            @(posedge clk_i);
            transfer(2, make_req(1'b1, word_adr(8'h30), 4'hf, 32'ha5a5_0002));
         end
         begin
            @(posedge clk_i);
            transfer(3, make_req(1'b0, word_adr(8'h30), 4'h0, 32'h0));
         end
      join
      check_equal("completions with a held cyc", done_order.size(), 4);
      check_equal("first completion with a held cyc", done_order[0], 1);
      check_equal("second completion with a held cyc", done_order[1], 1);

      // Hold requested while master 0 owns the bus
      start_req(0, make_req(1'b1, word_adr(8'h20), 4'hf, 32'h0bad_0000));
      wait_resp(0);
      end_req(0, 1'b1);
      done_order.delete();
      fork
         begin
            @(posedge clk_i);
            bus_hold_i <= 1'b1;
            repeat (3) begin
               @(negedge clk_i);
               check_equal("hold ack while master 0 owns the bus", bus_hold_ack_o, 1'b0);
            end
            @(posedge clk_i);
            m_req[0] <= '0;
            repeat (4) begin
               @(negedge clk_i);
               check_equal("hold ack after owner release", bus_hold_ack_o, 1'b1);
            end
            @(posedge clk_i);
            bus_hold_i <= 1'b0;
         end
         transfer(1, make_req(1'b1, word_adr(8'h21), 4'hf, 32'h0bad_0001));
         transfer(2, make_req(1'b0, word_adr(8'h20), 4'h0, 32'h0));
         transfer(3, make_req(1'b0, word_adr(8'h21), 4'h0, 32'h0));
      join
      check_equal("completions after hold", done_order.size(), 3);
      // Waiting set is 1..3, each winner is followed by the next one up, wrapping
      for (int k = 1; k < 3; k++) begin
         check_equal($sformatf("completion %0d after hold", k), done_order[k],
                     (done_order[k-1] % 3) + 1);
      end

      // Concurrent random traffic
      for (int m = 0; m < N_MASTERS; m++) begin
         for (int k = 0; k < RND_LEN; k++) begin
            rnd_req[m][k] = rand_req();
         end
      end
      done_order.delete();
      fork
         run_list(0);
         run_list(1);
         run_list(2);
         run_list(3);
      join
      check_equal("random completions", done_order.size(), N_MASTERS * RND_LEN);

      if (sva_fails != 0) begin
         $display("Bound assertions on the bus control failed %0d times", sva_fails);
         stop_run();
      end else begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule : tb_wb_shared_bus

/* verif/wb_shared_bus_sva.sv */
// Bound assertions on grant encoding, hold gating and grant stability of the bus control

`timescale 1ns/1ps

module wb_shared_bus_sva (
   input logic                 clk_i,
   input logic                 rst_i,
   input wb_bus_pkg::mst_vec_t cyc_i,
   input logic                 bus_hold_ack_i,
   input wb_bus_pkg::mst_vec_t grant_i
);

   // Number of assertion failures, read by the testbench
   int fail_cnt = 0;

   // At most one master drives the slave
   a_grant_onehot0 : assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0(grant_i))
   else begin
      fail_cnt++;
      $error("Grant is neither one-hot nor zero: %b", grant_i);
   end

   // Acknowledged hold blocks every master
   a_hold_no_grant : assert property (@(posedge clk_i) disable iff (rst_i)
      bus_hold_ack_i |-> grant_i == '0)
   else begin
      fail_cnt++;
      $error("Grant %b given while the hold is acknowledged", grant_i);
   end

   // Owner keeps the bus while its cyc stays up
   a_grant_stable : assert property (@(posedge clk_i) disable iff (rst_i)
      |($past(grant_i) & $past(cyc_i) & cyc_i) |-> grant_i == $past(grant_i))
   else begin
      fail_cnt++;
      $error("Grant moved to %b while owner still had cyc", grant_i);
   end

endmodule : wb_shared_bus_sva

// Attach to the bus control
bind wb_bus_ctrl wb_shared_bus_sva i_wb_shared_bus_sva (
   .clk_i          (clk_i),
   .rst_i          (rst_i),
   .cyc_i          (cyc_i),
   .bus_hold_ack_i (bus_hold_ack_o),
   .grant_i        (grant_o)
);

/* wb_shared_bus.f */
rtl/wb_cfg_pkg.sv
rtl/wb_bus_pkg.sv
rtl/wb_rr_arbiter.sv
rtl/wb_bus_ctrl.sv
rtl/wb_master_mux.sv
rtl/wb_ram_slave.sv
rtl/wb_shared_bus.sv
verif/wb_shared_bus_sva.sv
verif/tb_wb_shared_bus.sv
